//--- exec_pkg.sv
package exec_pkg;

    localparam int xlen = 32;
    localparam int tag_w = 5;        // Reorder buffer tag
    localparam int mult_stages = 4;  // Also the multiplier latency

    // Integer ALU operations
    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_and  = 4'd2;
    localparam logic [3:0] alu_or   = 4'd3;
    localparam logic [3:0] alu_xor  = 4'd4;
    localparam logic [3:0] alu_slt  = 4'd5;
    localparam logic [3:0] alu_sltu = 4'd6;
    localparam logic [3:0] alu_sll  = 4'd7;
    localparam logic [3:0] alu_srl  = 4'd8;
    localparam logic [3:0] alu_sra  = 4'd9;

    // Operand A sources
    localparam logic [1:0] opa_rs1  = 2'd0;
    localparam logic [1:0] opa_npc  = 2'd1;
    localparam logic [1:0] opa_pc   = 2'd2;
    localparam logic [1:0] opa_zero = 2'd3;

    // Operand B sources
    localparam logic [2:0] opb_rs2   = 3'd0;
    localparam logic [2:0] opb_i_imm = 3'd1;
    localparam logic [2:0] opb_s_imm = 3'd2;
    localparam logic [2:0] opb_b_imm = 3'd3;
    localparam logic [2:0] opb_u_imm = 3'd4;
    localparam logic [2:0] opb_j_imm = 3'd5;

    // Functional unit that takes the entry
    localparam logic [1:0] fu_alu = 2'd0;
    localparam logic [1:0] fu_mem = 2'd1;
    localparam logic [1:0] fu_mul = 2'd2;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
    } instr_word_t;

    function automatic logic [xlen-1:0] imm_i(instr_word_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic logic [xlen-1:0] imm_s(instr_word_t inst);
        return {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    endfunction

    function automatic logic [xlen-1:0] imm_b(instr_word_t inst);
        return {{20{inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    endfunction

    // Upper 20 bits of the word, low 12 cleared
    function automatic logic [xlen-1:0] imm_u(instr_word_t inst);
        return {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'b0};
    endfunction

    // J immediate is scattered over the I view fields
    function automatic logic [xlen-1:0] imm_j(instr_word_t inst);
        return {{12{inst.i.imm[11]}}, inst.i.rs1, inst.i.funct3, inst.i.imm[0],
                inst.i.imm[10:1], 1'b0};
    endfunction

endpackage

//--- issue_if.sv
interface issue_if;
    import exec_pkg::*;

    logic              valid;
    logic [1:0]        fu;
    logic [tag_w-1:0]  tag;
    logic [xlen-1:0]   rs1_value;
    logic [xlen-1:0]   rs2_value;
    instr_word_t       inst;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   npc;
    logic [1:0]        opa_sel;
    logic [2:0]        opb_sel;
    logic [3:0]        alu_func;
    logic              cond_branch;
    logic              uncond_branch;
    logic              rd_mem;          // Load when set, store otherwise
    logic              predict_taken;
    logic [xlen-1:0]   predict_target;

    modport source (
        output valid, fu, tag, rs1_value, rs2_value, inst, pc, npc, opa_sel, opb_sel,
               alu_func, cond_branch, uncond_branch, rd_mem, predict_taken, predict_target
    );

    modport sink (
        input valid, fu, tag, rs1_value, rs2_value, inst, pc, npc, opa_sel, opb_sel,
              alu_func, cond_branch, uncond_branch, rd_mem, predict_taken, predict_target
    );

endinterface

//--- operand_select.sv
module operand_select (
    issue_if.sink                    entry,
    output logic [exec_pkg::xlen-1:0] opa,
    output logic [exec_pkg::xlen-1:0] opb
);
    import exec_pkg::*;

    // Operand A
    always_comb begin
        case (entry.opa_sel)
            opa_rs1:  opa = entry.rs1_value;
            opa_npc:  opa = entry.npc;
            opa_pc:   opa = entry.pc;
            opa_zero: opa = '0;
            default:  opa = '0;
        endcase
    end

    // Operand B, immediates decoded through the union views
    always_comb begin
        case (entry.opb_sel)
            opb_rs2:   opb = entry.rs2_value;
            opb_i_imm: opb = imm_i(entry.inst);
            opb_s_imm: opb = imm_s(entry.inst);   // Store offset
            opb_b_imm: opb = imm_b(entry.inst);   // Branch offset
            opb_u_imm: opb = imm_u(entry.inst);
            opb_j_imm: opb = imm_j(entry.inst);
            default:   opb = '0;                  // Unknown selector
        endcase
    end

endmodule

//--- int_alu.sv
module int_alu (
    input  logic [exec_pkg::xlen-1:0] opa,
    input  logic [exec_pkg::xlen-1:0] opb,
    input  logic [3:0]                func,
    output logic [exec_pkg::xlen-1:0] result
);
    import exec_pkg::*;

    logic signed [xlen-1:0] signed_opa;
    logic signed [xlen-1:0] signed_opb;
    logic [4:0]             shamt;

    assign signed_opa = opa;
    assign signed_opb = opb;
    assign shamt = opb[4:0];  // Only the low five bits shift

    always_comb begin
        case (func)
            alu_add:  result = opa + opb;
            alu_sub:  result = opa - opb;
            alu_and:  result = opa & opb;
            alu_or:   result = opa | opb;
            alu_xor:  result = opa ^ opb;
            alu_slt:  result = {{(xlen-1){1'b0}}, signed_opa < signed_opb};
            alu_sltu: result = {{(xlen-1){1'b0}}, opa < opb};
            alu_sll:  result = opa << shamt;
            alu_srl:  result = opa >> shamt;
            alu_sra:  result = signed_opa >>> shamt;   // Keeps the sign bit
            default:  result = '0;
        endcase
    end

endmodule

//--- alu_unit.sv
module alu_unit (
    issue_if.sink                           entry,
    output logic                            alu_valid,
    output logic [exec_pkg::tag_w-1:0]      alu_tag,
    output logic [exec_pkg::xlen-1:0]       alu_value,
    output logic                            take_branch,
    output logic                            branch_mispredict,
    output logic [exec_pkg::xlen-1:0]       target_pc
);
    import exec_pkg::*;

    logic            active;
    logic            cond;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    logic [xlen-1:0] result;

    operand_select u_operands (
        .entry (entry),
        .opa   (opa),
        .opb   (opb)
    );

    int_alu u_alu (
        .opa    (opa),
        .opb    (opb),
        .func   (entry.alu_func),
        .result (result)
    );

    assign active = entry.valid && (entry.fu == fu_alu);

    // Branch condition on the register values
    always_comb begin
        case (entry.inst.b.funct3)
            3'b000:  cond = entry.rs1_value == entry.rs2_value;                   // beq
            3'b001:  cond = entry.rs1_value != entry.rs2_value;                   // bne
            3'b100:  cond = $signed(entry.rs1_value) < $signed(entry.rs2_value);  // blt
            3'b101:  cond = $signed(entry.rs1_value) >= $signed(entry.rs2_value); // bge
            3'b110:  cond = entry.rs1_value < entry.rs2_value;                    // bltu
            3'b111:  cond = entry.rs1_value >= entry.rs2_value;                   // bgeu
            default: cond = 1'b0;
        endcase
    end

    // Taken branch uses the ALU result as its target
    assign take_branch = active && (entry.uncond_branch || (entry.cond_branch && cond));
    assign branch_mispredict = active &&
        ((entry.predict_taken != take_branch) ||
         (take_branch && (entry.predict_target != result)));
    assign target_pc = take_branch ? result : entry.npc;

    assign alu_valid = active;
    assign alu_tag = entry.tag;

    always_comb begin
        if (take_branch)
            alu_value = entry.npc;   // Link value
        else if (entry.cond_branch || entry.uncond_branch)
            alu_value = '0;
        else
            alu_value = result;
    end

endmodule

//--- agu_unit.sv
module agu_unit (
    issue_if.sink                      entry,
    output logic                       load_valid,
    output logic [exec_pkg::tag_w-1:0] load_tag,
    output logic [exec_pkg::xlen-1:0]  load_addr,
    output logic [2:0]                 load_size,
    output logic                       store_valid,
    output logic [exec_pkg::tag_w-1:0] store_tag,
    output logic [exec_pkg::xlen-1:0]  store_addr
);
    import exec_pkg::*;

    logic            active;
    logic [xlen-1:0] base;
    logic [xlen-1:0] offset;
    logic [xlen-1:0] address;

    operand_select u_operands (
        .entry (entry),
        .opa   (base),
        .opb   (offset)
    );

    // Effective address is always base plus offset
    int_alu u_adder (
        .opa    (base),
        .opb    (offset),
        .func   (alu_add),
        .result (address)
    );

    assign active = entry.valid && (entry.fu == fu_mem);

    assign load_valid = active && entry.rd_mem;
    assign load_tag = entry.tag;
    assign load_addr = address;
    assign load_size = entry.inst.r.funct3;   // Byte, half or word with sign

    assign store_valid = active && !entry.rd_mem;
    assign store_tag = entry.tag;
    assign store_addr = address;

endmodule

//--- mult_stage.sv
module mult_stage (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start_in,
    input  logic [exec_pkg::xlen-1:0] product_in,
    input  logic [exec_pkg::xlen-1:0] mplier_in,
    input  logic [exec_pkg::xlen-1:0] mcand_in,
    output logic                      start_out,
    output logic [exec_pkg::xlen-1:0] product_out,
    output logic [exec_pkg::xlen-1:0] mplier_out,
    output logic [exec_pkg::xlen-1:0] mcand_out
);
    import exec_pkg::*;

    logic [xlen-1:0] partial;

    // Slice of the multiplier handled here
    assign partial = mcand_in * mplier_in[xlen/mult_stages-1:0];

    always_ff @(posedge clock) begin
        product_out <= product_in + partial;
        mplier_out  <= mplier_in >> (xlen / mult_stages);   // Next slice to the bottom
        mcand_out   <= mcand_in << (xlen / mult_stages);
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            start_out <= 1'b0;
        end else begin
            start_out <= start_in;
        end
    end

endmodule

//--- mult_unit.sv
module mult_unit (
    input  logic                       clock,
    input  logic                       reset,
    issue_if.sink                      entry,
    output logic                       mul_valid,
    output logic [exec_pkg::tag_w-1:0] mul_tag,
    output logic [exec_pkg::xlen-1:0]  mul_npc,
    output logic [exec_pkg::xlen-1:0]  mul_value
);
    import exec_pkg::*;

    logic [xlen-1:0]  mcand;
    logic [xlen-1:0]  mplier;
    logic             start    [mult_stages+1];
    logic [xlen-1:0]  product  [mult_stages+1];
    logic [xlen-1:0]  mplier_c [mult_stages];
    logic [xlen-1:0]  mcand_c  [mult_stages];
    logic [tag_w-1:0] tag_pipe [mult_stages];
    logic [xlen-1:0]  npc_pipe [mult_stages];

    operand_select u_operands (
        .entry (entry),
        .opa   (mcand),
        .opb   (mplier)
    );

    assign start[0] = entry.valid && (entry.fu == fu_mul);
    assign product[0] = '0;
    assign mplier_c[0] = mplier;
    assign mcand_c[0] = mcand;

    for (genvar i = 0; i < mult_stages; i++) begin : g_stage
        if (i < mult_stages - 1) begin : g_mid
            mult_stage u_stage (
                .clock       (clock),
                .reset       (reset),
                .start_in    (start[i]),
                .product_in  (product[i]),
                .mplier_in   (mplier_c[i]),
                .mcand_in    (mcand_c[i]),
                .start_out   (start[i+1]),
                .product_out (product[i+1]),
                .mplier_out  (mplier_c[i+1]),
                .mcand_out   (mcand_c[i+1])
            );
        end else begin : g_last
            // Shifted operands are not needed past the last slice
            mult_stage u_stage (
                .clock       (clock),
                .reset       (reset),
                .start_in    (start[i]),
                .product_in  (product[i]),
                .mplier_in   (mplier_c[i]),
                .mcand_in    (mcand_c[i]),
                .start_out   (start[i+1]),
                .product_out (product[i+1]),
                .mplier_out  (),
                .mcand_out   ()
            );
        end
    end

    // Tag and npc ride along with the done bits
    always_ff @(posedge clock) begin
        tag_pipe[0] <= entry.tag;
        npc_pipe[0] <= entry.npc;
        for (int i = 1; i < mult_stages; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
            npc_pipe[i] <= npc_pipe[i-1];
        end
    end

    assign mul_valid = start[mult_stages];
    assign mul_tag = tag_pipe[mult_stages-1];
    assign mul_npc = npc_pipe[mult_stages-1];
    assign mul_value = product[mult_stages];   // Low word of the product

endmodule

//--- exec_stage.sv
module exec_stage (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       issue_valid,
    input  logic [1:0]                 issue_fu,
    input  logic [exec_pkg::tag_w-1:0] issue_tag,
    input  logic [exec_pkg::xlen-1:0]  issue_rs1_value,
    input  logic [exec_pkg::xlen-1:0]  issue_rs2_value,
    input  logic [31:0]                issue_inst,
    input  logic [exec_pkg::xlen-1:0]  issue_pc,
    input  logic [exec_pkg::xlen-1:0]  issue_npc,
    input  logic [1:0]                 issue_opa_sel,
    input  logic [2:0]                 issue_opb_sel,
    input  logic [3:0]                 issue_alu_func,
    input  logic                       issue_cond_branch,
    input  logic                       issue_uncond_branch,
    input  logic                       issue_rd_mem,
    input  logic                       issue_predict_taken,
    input  logic [exec_pkg::xlen-1:0]  issue_predict_target,
    output logic                       alu_valid,
    output logic [exec_pkg::tag_w-1:0] alu_tag,
    output logic [exec_pkg::xlen-1:0]  alu_value,
    output logic                       take_branch,
    output logic                       branch_mispredict,
    output logic [exec_pkg::xlen-1:0]  target_pc,
    output logic                       load_valid,
    output logic [exec_pkg::tag_w-1:0] load_tag,
    output logic [exec_pkg::xlen-1:0]  load_addr,
    output logic [2:0]                 load_size,
    output logic                       store_valid,
    output logic [exec_pkg::tag_w-1:0] store_tag,
    output logic [exec_pkg::xlen-1:0]  store_addr,
    output logic                       mul_valid,
    output logic [exec_pkg::tag_w-1:0] mul_tag,
    output logic [exec_pkg::xlen-1:0]  mul_npc,
    output logic [exec_pkg::xlen-1:0]  mul_value
);

    issue_if issue ();

    // Every unit sees the same entry and picks out its own fu code
    assign issue.valid          = issue_valid;
    assign issue.fu             = issue_fu;
    assign issue.tag            = issue_tag;
    assign issue.rs1_value      = issue_rs1_value;
    assign issue.rs2_value      = issue_rs2_value;
    assign issue.inst           = issue_inst;
    assign issue.pc             = issue_pc;
    assign issue.npc            = issue_npc;
    assign issue.opa_sel        = issue_opa_sel;
    assign issue.opb_sel        = issue_opb_sel;
    assign issue.alu_func       = issue_alu_func;
    assign issue.cond_branch    = issue_cond_branch;
    assign issue.uncond_branch  = issue_uncond_branch;
    assign issue.rd_mem         = issue_rd_mem;
    assign issue.predict_taken  = issue_predict_taken;
    assign issue.predict_target = issue_predict_target;

    alu_unit u_alu (
        .entry             (issue.sink),
        .alu_valid         (alu_valid),
        .alu_tag           (alu_tag),
        .alu_value         (alu_value),
        .take_branch       (take_branch),
        .branch_mispredict (branch_mispredict),
        .target_pc         (target_pc)
    );

    agu_unit u_agu (
        .entry       (issue.sink),
        .load_valid  (load_valid),
        .load_tag    (load_tag),
        .load_addr   (load_addr),
        .load_size   (load_size),
        .store_valid (store_valid),
        .store_tag   (store_tag),
        .store_addr  (store_addr)
    );

    mult_unit u_mult (
        .clock     (clock),
        .reset     (reset),
        .entry     (issue.sink),
        .mul_valid (mul_valid),
        .mul_tag   (mul_tag),
        .mul_npc   (mul_npc),
        .mul_value (mul_value)
    );

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic clock
);
    timeunit 1ns;
    timeprecision 100ps;

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

endmodule

//--- exec_chk.sv
module exec_chk (
    input logic       clock,
    input logic       reset,
    input logic       issue_valid,
    input logic [1:0] issue_fu,
    input logic       alu_valid,
    input logic       branch_mispredict,
    input logic       load_valid,
    input logic       store_valid,
    input logic       mul_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import exec_pkg::*;

    logic mul_issue;

    assign mul_issue = issue_valid && (issue_fu == fu_mul);

    // A memory entry goes to one side only
    mem_one_side: assert property (@(posedge clock) disable iff (reset)
        !(load_valid && store_valid))
        else $error("load_valid and store_valid high in the same cycle");

    mul_latency: assert property (@(posedge clock) disable iff (reset)
        mul_valid == $past(mul_issue, mult_stages))   // Fixed multiplier latency
        else $error("mul_valid does not follow a multiply issue by the pipeline depth");

    mispredict_needs_alu: assert property (@(posedge clock) disable iff (reset)
        branch_mispredict |-> alu_valid)
        else $error("branch_mispredict raised without alu_valid");

endmodule

bind exec_stage exec_chk chk (
    .clock             (clock),
    .reset             (reset),
    .issue_valid       (issue_valid),
    .issue_fu          (issue_fu),
    .alu_valid         (alu_valid),
    .branch_mispredict (branch_mispredict),
    .load_valid        (load_valid),
    .store_valid       (store_valid),
    .mul_valid         (mul_valid)
);

//--- exec_tb.sv
module exec_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import exec_pkg::*;

    localparam int num_tests = 400;
    localparam int clock_period = 8;
    localparam int reset_cycles = 8;

    logic              clock;
    logic              reset;
    logic              issue_valid;
    logic [1:0]        issue_fu;
    logic [tag_w-1:0]  issue_tag;
    logic [xlen-1:0]   issue_rs1_value;
    logic [xlen-1:0]   issue_rs2_value;
    logic [31:0]       issue_inst;
    logic [xlen-1:0]   issue_pc;
    logic [xlen-1:0]   issue_npc;
    logic [1:0]        issue_opa_sel;
    logic [2:0]        issue_opb_sel;
    logic [3:0]        issue_alu_func;
    logic              issue_cond_branch;
    logic              issue_uncond_branch;
    logic              issue_rd_mem;
    logic              issue_predict_taken;
    logic [xlen-1:0]   issue_predict_target;
    logic              alu_valid;
    logic [tag_w-1:0]  alu_tag;
    logic [xlen-1:0]   alu_value;
    logic              take_branch;
    logic              branch_mispredict;
    logic [xlen-1:0]   target_pc;
    logic              load_valid;
    logic [tag_w-1:0]  load_tag;
    logic [xlen-1:0]   load_addr;
    logic [2:0]        load_size;
    logic              store_valid;
    logic [tag_w-1:0]  store_tag;
    logic [xlen-1:0]   store_addr;
    logic              mul_valid;
    logic [tag_w-1:0]  mul_tag;
    logic [xlen-1:0]   mul_npc;
    logic [xlen-1:0]   mul_value;

    integer            seed;
    string             current_test;
    logic              exp_alu_valid;
    logic              exp_take;
    logic              exp_mispredict;
    logic              exp_load_valid;
    logic              exp_store_valid;
    logic [xlen-1:0]   exp_alu_value;
    logic [xlen-1:0]   exp_target;
    logic [xlen-1:0]   exp_addr;

    // Multiplier results in flight, oldest first
    int                exp_due [$];
    logic [tag_w-1:0]  exp_tag [$];
    logic [xlen-1:0]   exp_npc [$];
    logic [xlen-1:0]   exp_product [$];

    tb_clock clock_gen (.clock(clock));

    exec_stage uut (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string test, input string field,
                              input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("** Error [%s] %s: expected %h, actual %h",
                                        test, field, expected, actual));
    endtask

    task automatic check_tag(input string test, input string field,
                             input logic [tag_w-1:0] expected, input logic [tag_w-1:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("** Error [%s] %s: expected %h, actual %h",
                                        test, field, expected, actual));
    endtask

    task automatic check_size(input string test, input string field,
                              input logic [2:0] expected, input logic [2:0] actual);
        if (actual !== expected)
            stop_with_failure($sformatf("** Error [%s] %s: expected %h, actual %h",
                                        test, field, expected, actual));
    endtask

    task automatic check_bit(input string test, input string field,
                             input logic expected, input logic actual);
        if (actual !== expected)
            stop_with_failure($sformatf("** Error [%s] %s: expected %b, actual %b",
                                        test, field, expected, actual));
    endtask

    function automatic int random_below(input int limit);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % limit;
    endfunction

    function automatic logic signed_less(input logic [xlen-1:0] x, input logic [xlen-1:0] y);
        if (x[xlen-1] != y[xlen-1])
            return x[xlen-1];   // Negative side is smaller
        return x < y;
    endfunction

    function automatic logic [xlen-1:0] operand_b_model(input logic [2:0] sel,
                                                       input logic [xlen-1:0] rs2,
                                                       input logic [31:0] w);
        case (sel)
            opb_rs2:   return rs2;
            opb_i_imm: return {{20{w[31]}}, w[31:20]};
            opb_s_imm: return {{20{w[31]}}, w[31:25], w[11:7]};
            opb_b_imm: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            opb_u_imm: return {w[31:12], 12'b0};
            opb_j_imm: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:   return '0;
        endcase
    endfunction

    function automatic logic [xlen-1:0] alu_model(input logic [3:0] f,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return {31'b0, signed_less(a, b)};
            alu_sltu: return {31'b0, a < b};
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return (a >> b[4:0]) | (~({xlen{1'b1}} >> b[4:0]) & {xlen{a[xlen-1]}});
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [xlen-1:0] x,
                                          input logic [xlen-1:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return signed_less(x, y);
            3'b101:  return !signed_less(x, y);
            3'b110:  return x < y;
            3'b111:  return !(x < y);
            default: return 1'b0;
        endcase
    endfunction

    task automatic clear_entry();
        issue_valid = 1'b0;
        issue_fu = fu_alu;
        issue_tag = '0;
        issue_rs1_value = '0;
        issue_rs2_value = '0;
        issue_inst = '0;
        issue_pc = '0;
        issue_npc = '0;
        issue_opa_sel = opa_rs1;
        issue_opb_sel = opb_rs2;
        issue_alu_func = alu_add;
        issue_cond_branch = 1'b0;
        issue_uncond_branch = 1'b0;
        issue_rd_mem = 1'b0;
        issue_predict_taken = 1'b0;
        issue_predict_target = '0;
    endtask

    task automatic issue_random_entry(input int n, input bit allow_issue);
        int              kind;
        int              pick;
        logic [2:0]      f3;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] sum;
        logic            alu_active;
        clear_entry();
        kind = random_below(6);
        issue_valid = allow_issue && (random_below(8) != 0);
        issue_tag = tag_w'(random_below(1 << tag_w));
        issue_rs1_value = $random(seed);
        issue_rs2_value = $random(seed);
        issue_inst = $random(seed);
        issue_pc = $random(seed) & 32'hffff_fffc;
        issue_npc = issue_pc + 32'd4;
        issue_alu_func = 4'(random_below(10));
        case (kind)
            0, 1: begin
                current_test = "alu op";
                issue_opa_sel = (random_below(2) != 0) ? opa_pc : opa_rs1;
                pick = random_below(3);
                issue_opb_sel = (pick == 0) ? opb_rs2 : (pick == 1) ? opb_i_imm : opb_u_imm;
            end
            2: begin
                current_test = "branch";
                issue_cond_branch = 1'b1;
                f3 = 3'(random_below(6));
                if (f3 >= 3'd2)
                    f3 = f3 + 3'd2;   // Skip the two unused codes
                issue_inst[14:12] = f3;
                if (random_below(4) == 0)
                    issue_rs2_value = issue_rs1_value;
                issue_opa_sel = opa_pc;
                issue_opb_sel = opb_b_imm;
                issue_alu_func = alu_add;
            end
            3: begin
                current_test = "jump";
                issue_uncond_branch = 1'b1;
                issue_alu_func = alu_add;
                if (random_below(2) != 0) begin
                    issue_opb_sel = opb_i_imm;   // jalr
                end else begin
                    issue_opa_sel = opa_pc;
                    issue_opb_sel = opb_j_imm;
                end
            end
            4: begin
                current_test = "memory";
                issue_fu = fu_mem;
                issue_rd_mem = random_below(2) != 0;
                issue_opb_sel = issue_rd_mem ? opb_i_imm : opb_s_imm;
            end
            default: begin
                current_test = "multiply";
                issue_fu = fu_mul;
            end
        endcase
        if (!issue_valid)
            current_test = "idle";

        case (issue_opa_sel)
            opa_rs1: a = issue_rs1_value;
            opa_npc: a = issue_npc;
            opa_pc:  a = issue_pc;
            default: a = '0;
        endcase
        b = operand_b_model(issue_opb_sel, issue_rs2_value, issue_inst);
        sum = alu_model(issue_alu_func, a, b);

        // Half of the predictions carry the real target
        issue_predict_taken = random_below(2) != 0;
        issue_predict_target = (random_below(2) != 0) ? sum : $random(seed);

        alu_active = issue_valid && (issue_fu == fu_alu);
        exp_alu_valid = alu_active;
        exp_take = alu_active && (issue_uncond_branch || (issue_cond_branch &&
                   branch_model(issue_inst[14:12], issue_rs1_value, issue_rs2_value)));
        exp_mispredict = alu_active && ((issue_predict_taken != exp_take) ||
                         (exp_take && (issue_predict_target != sum)));
        exp_target = exp_take ? sum : issue_npc;
        if (exp_take)
            exp_alu_value = issue_npc;
        else if (issue_cond_branch || issue_uncond_branch)
            exp_alu_value = '0;
        else
            exp_alu_value = sum;
        exp_load_valid = issue_valid && (issue_fu == fu_mem) && issue_rd_mem;
        exp_store_valid = issue_valid && (issue_fu == fu_mem) && !issue_rd_mem;
        exp_addr = a + b;
        if (issue_valid && (issue_fu == fu_mul)) begin
            exp_due.push_back(n + mult_stages);
            exp_tag.push_back(issue_tag);
            exp_npc.push_back(issue_npc);
            exp_product.push_back(a * b);   // Low word only
        end
    endtask

    task automatic check_outputs(input int n);
        logic [tag_w-1:0] tag_front;
        logic [xlen-1:0] npc_front;
        logic [xlen-1:0] product_front;
        check_bit(current_test, "alu_valid", exp_alu_valid, alu_valid);
        check_bit(current_test, "take_branch", exp_take, take_branch);
        check_bit(current_test, "branch_mispredict", exp_mispredict, branch_mispredict);
        if (exp_alu_valid) begin
            check_tag(current_test, "alu_tag", issue_tag, alu_tag);
            check_word(current_test, "alu_value", exp_alu_value, alu_value);
            check_word(current_test, "target_pc", exp_target, target_pc);
        end
        check_bit(current_test, "load_valid", exp_load_valid, load_valid);
        check_bit(current_test, "store_valid", exp_store_valid, store_valid);
        if (exp_load_valid) begin
            check_tag(current_test, "load_tag", issue_tag, load_tag);
            check_word(current_test, "load_addr", exp_addr, load_addr);
            check_size(current_test, "load_size", issue_inst[14:12], load_size);
        end
        if (exp_store_valid) begin
            check_tag(current_test, "store_tag", issue_tag, store_tag);
            check_word(current_test, "store_addr", exp_addr, store_addr);
        end
        if (exp_due.size() != 0 && exp_due[0] == n) begin
            void'(exp_due.pop_front());
            tag_front = exp_tag.pop_front();
            npc_front = exp_npc.pop_front();
            product_front = exp_product.pop_front();
            check_bit("multiply", "mul_valid", 1'b1, mul_valid);
            check_tag("multiply", "mul_tag", tag_front, mul_tag);
            check_word("multiply", "mul_npc", npc_front, mul_npc);
            check_word("multiply", "mul_value", product_front, mul_value);
        end else begin
            check_bit("multiply", "mul_valid", 1'b0, mul_valid);
        end
    endtask

    initial begin
        seed = 32'hb9f0;
        current_test = "reset";
        reset = 1'b1;
        clear_entry();
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clock);
            #1;
            check_bit("reset", "mul_valid", 1'b0, mul_valid);
        end
        reset = 1'b0;
        // Last few cycles issue nothing so the multiplier drains
        for (int n = 0; n < num_tests + mult_stages; n++) begin
            @(posedge clock);
            #1;
            issue_random_entry(n, n < num_tests);
            #3;
            check_outputs(n);
        end
        if (exp_due.size() != 0) begin
            stop_with_failure("Multiplier results were still missing at the end of the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

    initial begin
        #(num_tests * 10 * clock_period);
        stop_with_failure("Watchdog timeout, the tests did not finish in time");
    end

endmodule

//--- project.f
exec_pkg.sv
issue_if.sv
operand_select.sv
int_alu.sv
alu_unit.sv
agu_unit.sv
mult_stage.sv
mult_unit.sv
exec_stage.sv
tb_clock.sv
exec_chk.sv
exec_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module exec_tb -f project.f --Mdir obj_dir -o exec_sim

./obj_dir/exec_sim 2>&1 | tee sim.log

# Fails the script unless the pass line is in the log
grep -qx "test passed" sim.log
